// File: dv/coreStim.txt
# name valid instr pc cfgValid cfgData irq | expWb expAddr expData expBr expTgt expAck
# A name of - marks an idle or config cycle with nothing to check
addi_r1    1 20201234 00000100 0 00000000 0 1 01 00001234 0 00000000 0
addi_r2    1 2040fff0 00000104 0 00000000 0 1 02 fffffff0 0 00000000 0
addi_r3    1 20600f0f 00000108 0 00000000 0 1 03 00000f0f 0 00000000 0
add_r4     1 00811000 0000010c 0 00000000 0 1 04 00001224 0 00000000 0
sub_r5     1 04a11800 00000110 0 00000000 0 1 05 00000325 0 00000000 0
and_r6     1 84c11800 00000114 0 00000000 0 1 06 00000204 0 00000000 0
or_r7      1 80e11800 00000118 0 00000000 0 1 07 00001f3f 0 00000000 0
xor_r8     1 89011800 0000011c 0 00000000 0 1 08 00001d3b 0 00000000 0
srl_r9     1 91221800 00000120 0 00000000 0 1 09 0001ffff 0 00000000 0
subi_r10   1 25410005 00000124 0 00000000 0 1 0a 0000122f 0 00000000 0
andi_r4    1 a48200ff 00000128 0 00000000 0 1 04 000000f0 0 00000000 0
ori_r5     1 a0a37000 0000012c 0 00000000 0 1 05 00007f0f 0 00000000 0
xori_r6    1 a8c1ffff 00000130 0 00000000 0 1 06 ffffedcb 0 00000000 0
srli_r7    1 b0e20004 00000134 0 00000000 0 1 07 0fffffff 0 00000000 0
fwd_load   1 20200007 00000138 0 00000000 0 1 01 00000007 0 00000000 0
fwd_ab     1 00410800 0000013c 0 00000000 0 1 02 0000000e 0 00000000 0
fwd_gap    1 04620800 00000140 0 00000000 0 1 03 00000007 0 00000000 0
fwd_gap2   1 00a31000 00000144 0 00000000 0 1 05 00000015 0 00000000 0
r0_write   1 20000055 00000148 0 00000000 0 0 00 00000000 0 00000000 0
r0_read    1 00c00800 0000014c 0 00000000 0 1 06 00000007 0 00000000 0
brl_reg    1 99002800 00000200 0 00000000 0 1 08 00000200 1 00000015 0
brl_imm    1 b9200400 00000204 0 00000000 0 1 09 00000204 1 00000400 0
brl_r0     1 b8000800 00000208 0 00000000 0 0 00 00000000 1 00000800 0
-          0 00000000 00000000 1 00000301 0 0 00 00000000 0 00000000 0
-          0 00000000 00000000 0 00000000 1 0 00 00000000 0 00000000 0
irq_take   1 20200001 00000210 0 00000000 0 1 0e 00000210 1 00000300 1
irq_after  1 20400003 00000214 0 00000000 0 1 02 00000003 0 00000000 0
-          0 00000000 00000000 0 00000000 1 0 00 00000000 0 00000000 0
irq_masked 1 20600009 00000218 0 00000000 0 1 03 00000009 0 00000000 0
-          0 00000000 00000000 1 00000501 0 0 00 00000000 0 00000000 0
-          0 00000000 00000000 0 00000000 1 0 00 00000000 0 00000000 0
irq_rearm  1 20200001 00000220 0 00000000 0 1 0e 00000220 1 00000500 1

// File: tb.f
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/irqCtrl.sv
rtl/instrDecode.sv
rtl/regFile.sv
rtl/aluExec.sv
rtl/coreTop.sv
dv/wbChecker.sv
dv/tbTop.sv

// File: dv/tbTop.sv
`default_nettype none

module tbTop;

  localparam logic [31:0] VecReset = 32'h0000_0100;
  localparam int MaxLines = 200;
  localparam int DrainLimit = 20;

  logic        gclk;
  logic        arstN;
  logic        instrValid;
  logic [31:0] instrWord;
  logic [31:0] instrPc;
  logic        cfgValid;
  logic [31:0] cfgData;
  logic        irq;
  wire         wbValid;
  wire  [4:0]  wbAddr;
  wire  [31:0] wbData;
  wire         branchValid;
  wire  [31:0] branchTarget;
  wire         irqAck;

  coreTop #(.IrqVectorReset(VecReset)) dut0 (
    .gclk, .arstN, .instrValid, .instrWord, .instrPc, .cfgValid, .cfgData, .irq,
    .wbValid, .wbAddr, .wbData, .branchValid, .branchTarget, .irqAck
  );

  wbChecker chk0 (
    .gclk, .arstN, .wbValid, .wbAddr, .wbData, .branchValid, .branchTarget, .irqAck
  );

  initial gclk = 1'b0;
  always #10 gclk = ~gclk;

  initial begin
    int          fd;
    int          nFields;
    int          lineCnt;
    int          waitCnt;
    string       line;
    string       name;
    logic [31:0] v, word, pc, cv, cd, lvl;
    logic [31:0] expWb, expAddr, expData, expBr, expTgt, expAck;
    arstN      = 1'b0;
    instrValid = 1'b0;
    instrWord  = '0;
    instrPc    = '0;
    cfgValid   = 1'b0;
    cfgData    = '0;
    irq        = 1'b0;
    fd = $fopen("dv/coreStim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file dv/coreStim.txt");
      $display("STATUS: FAIL");
      $finish;
    end else begin
      repeat (5) @(posedge gclk);
      arstN <= 1'b1;
      lineCnt = 0;
      while (!$feof(fd) && lineCnt < MaxLines) begin
        lineCnt++;
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.substr(0, 0) == "#") continue;
        nFields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h", name, v, word,
                          pc, cv, cd, lvl, expWb, expAddr, expData, expBr, expTgt, expAck);
        if (nFields != 13) begin
          $display("Stimulus line %0d is malformed and was skipped", lineCnt);
          chk0.noteFailure();
          continue;
        end
        @(posedge gclk);
        instrValid <= v[0];
        instrWord  <= word;
        instrPc    <= pc;
        cfgValid   <= cv[0];
        cfgData    <= cd;
        irq        <= lvl[0];
        // Only strobed instructions carry an expectation
        if (v[0]) begin
          chk0.pushExpect(name, expWb[0], expAddr[4:0], expData, expBr[0], expTgt,
                          expAck[0]);
        end
      end
      $fclose(fd);
      @(posedge gclk);
      instrValid <= 1'b0;
      cfgValid   <= 1'b0;
      irq        <= 1'b0;
      waitCnt = 0;
      while (chk0.queued() != 0 && waitCnt < DrainLimit) begin
        @(posedge gclk);
        waitCnt++;
      end
      if (chk0.queued() != 0) begin
        $display("Timed out with %0d expected results never checked", chk0.queued());
        chk0.noteFailure();
      end
      $display("Tests passed %0d, failed %0d", chk0.passCount, chk0.failCount);
      if (chk0.failCount == 0) begin
        $display("STATUS: PASS");
      end else begin
        $display("STATUS: FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: dv/wbChecker.sv
`default_nettype none

module wbChecker (
  input wire        gclk,
  input wire        arstN,
  input wire        wbValid,
  input wire [4:0]  wbAddr,
  input wire [31:0] wbData,
  input wire        branchValid,
  input wire [31:0] branchTarget,
  input wire        irqAck
);

  int          passCount = 0;
  int          failCount = 0;
  int          negCount  = 0;
  logic        ackSeen   = 1'b0;
  string       nameQ[$];
  int          dueQ[$];
  logic        wbQ[$];
  logic [4:0]  addrQ[$];
  logic [31:0] dataQ[$];
  logic        brQ[$];
  logic [31:0] tgtQ[$];
  logic        ackQ[$];

  // Result is due on the third falling edge after the drive edge
  task automatic pushExpect(input string nm, input logic ew, input logic [4:0] ea,
                            input logic [31:0] ed, input logic eb, input logic [31:0] et,
                            input logic ek);
    nameQ.push_back(nm);
    dueQ.push_back(negCount + 3);
    wbQ.push_back(ew);
    addrQ.push_back(ea);
    dataQ.push_back(ed);
    brQ.push_back(eb);
    tgtQ.push_back(et);
    ackQ.push_back(ek);
  endtask

  function automatic int queued();
    return dueQ.size();
  endfunction

  task automatic noteFailure();
    failCount++;
  endtask

  task automatic compareFront();
    string nm;
    int    bad;
    nm  = nameQ.pop_front();
    bad = 0;
    if (wbValid !== wbQ[0]) begin
      $display("Error %s: wbValid expected %0b actual %0b", nm, wbQ[0], wbValid);
      bad++;
    end else if (wbQ[0] && (wbAddr !== addrQ[0] || wbData !== dataQ[0])) begin
      $display("Error %s: wbAddr/wbData expected %0d/%h actual %0d/%h", nm, addrQ[0],
               dataQ[0], wbAddr, wbData);
      bad++;
    end
    if (branchValid !== brQ[0]) begin
      $display("Error %s: branchValid expected %0b actual %0b", nm, brQ[0], branchValid);
      bad++;
    end else if (brQ[0] && branchTarget !== tgtQ[0]) begin
      $display("Error %s: branchTarget expected %h actual %h", nm, tgtQ[0], branchTarget);
      bad++;
    end
    if (ackSeen !== ackQ[0]) begin
      $display("Error %s: irqAck expected %0b actual %0b", nm, ackQ[0], ackSeen);
      bad++;
    end
    if (bad == 0) begin
      $display("Test %s passed", nm);
      passCount++;
    end else begin
      failCount++;
    end
    void'(dueQ.pop_front());
    void'(wbQ.pop_front());
    void'(addrQ.pop_front());
    void'(dataQ.pop_front());
    void'(brQ.pop_front());
    void'(tgtQ.pop_front());
    void'(ackQ.pop_front());
  endtask

  // Falling edge keeps sampling away from the drive edge
  always @(negedge gclk) begin
    if (arstN) begin
      negCount++;
      if (dueQ.size() > 0 && dueQ[0] == negCount) begin
        compareFront();
      end else if (wbValid || branchValid) begin
        $display("Writeback or branch strobe appeared with no instruction expecting it");
        failCount++;
      end
      ackSeen = irqAck;  // Ack leads the strobe by one cycle
    end
  end

endmodule

`default_nettype wire

// File: rtl/coreTop.sv
`default_nettype none

module coreTop #(
  parameter logic [31:0] IrqVectorReset = 32'h0000_0010
) (
  input  logic          gclk,
  input  logic          arstN,
  input  logic          instrValid,
  input  isaPkg::instrT instrWord,
  input  logic [31:0]   instrPc,
  input  logic          cfgValid,
  input  logic [31:0]   cfgData,
  input  logic          irq,
  output logic          wbValid,
  output logic [4:0]    wbAddr,
  output logic [31:0]   wbData,
  output logic          branchValid,
  output logic [31:0]   branchTarget,
  output logic          irqAck
);

  import ctrlPkg::*;

  logic        irqReq;
  logic [31:0] irqVector;
  logic [4:0]  rdAddrA;
  logic [4:0]  rdAddrB;
  logic [31:0] rdDataA;
  logic [31:0] rdDataB;
  issueT       issue;
  wbT          wb;

  irqCtrl #(.IrqVectorReset(IrqVectorReset)) uIrq (
    .gclk, .arstN, .cfgValid, .cfgData, .irq, .irqAck, .irqReq, .irqVector
  );

  instrDecode uDecode (
    .gclk, .arstN, .instrValid, .instrWord, .instrPc, .irqReq, .irqVector,
    .rdDataA, .rdDataB, .rdAddrA, .rdAddrB, .issue, .irqAck
  );

  regFile uRegs (.gclk, .arstN, .rdAddrA, .rdAddrB, .wb, .rdDataA, .rdDataB);

  aluExec uAlu (.gclk, .arstN, .issue, .wb, .branchValid, .branchTarget);

  // Writeback strobe out to the ports
  assign wbValid = wb.valid;
  assign wbAddr  = wb.rd;
  assign wbData  = wb.data;

endmodule

`default_nettype wire

// File: rtl/aluExec.sv
`default_nettype none

module aluExec (
  input  logic           gclk,
  input  logic           arstN,
  input  ctrlPkg::issueT issue,
  output ctrlPkg::wbT    wb,
  output logic           branchValid,
  output logic [31:0]    branchTarget
);

  import ctrlPkg::*;

  logic [31:0] aVal;
  logic [31:0] bVal;
  logic [31:0] result;

  // Operand A from register, forwarded result or pc
  always_comb begin
    case (issue.srcA)
      selFwd:  aVal = wb.data;
      selPc:   aVal = issue.pc;
      default: aVal = issue.opA;
    endcase
  end

  // Operand B from register, forwarded result or immediate
  always_comb begin
    case (issue.srcB)
      selFwd:  bVal = wb.data;
      selImm:  bVal = issue.imm;
      default: bVal = issue.opB;
    endcase
  end

  always_comb begin
    case (issue.aluOp)
      aluAdd:  result = aVal + bVal;
      aluSub:  result = aVal - bVal;
      aluAnd:  result = aVal & bVal;
      aluOr:   result = aVal | bVal;
      aluXor:  result = aVal ^ bVal;
      aluSrl:  result = aVal >> bVal[4:0];
      default: result = aVal;  // Pass gives the link value for branches
    endcase
  end

  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      wb <= '0;
    end else begin
      wb.valid <= issue.valid && issue.we;
      wb.rd    <= issue.rd;
      wb.data  <= result;
      wb.link  <= issue.valid && issue.link;
    end
  end

  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      branchTarget <= '0;
    end else begin
      branchTarget <= bVal;
    end
  end

  assign branchValid = wb.link;

endmodule

`default_nettype wire

// File: rtl/regFile.sv
`default_nettype none

module regFile (
  input  logic        gclk,
  input  logic        arstN,
  input  logic [4:0]  rdAddrA,
  input  logic [4:0]  rdAddrB,
  input  ctrlPkg::wbT wb,
  output logic [31:0] rdDataA,
  output logic [31:0] rdDataB
);

  logic [31:0] regs [32];
  logic        wrEn;

  assign wrEn = wb.valid && (wb.rd != 5'd0);

  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Write-first bypass covers the instruction two ahead
  always_comb begin
    rdDataA = regs[rdAddrA];
    rdDataB = regs[rdAddrB];
    if (wrEn && (wb.rd == rdAddrA)) rdDataA = wb.data;
    if (wrEn && (wb.rd == rdAddrB)) rdDataB = wb.data;
    if (rdAddrA == 5'd0) rdDataA = '0;  // r0 always zero
    if (rdAddrB == 5'd0) rdDataB = '0;
  end

endmodule

`default_nettype wire

// File: rtl/instrDecode.sv
`default_nettype none

module instrDecode (
  input  logic           gclk,
  input  logic           arstN,
  input  logic           instrValid,
  input  isaPkg::instrT  instrWord,
  input  logic [31:0]    instrPc,
  input  logic           irqReq,
  input  logic [31:0]    irqVector,
  input  logic [31:0]    rdDataA,
  input  logic [31:0]    rdDataB,
  output logic [4:0]     rdAddrA,
  output logic [4:0]     rdAddrB,
  output ctrlPkg::issueT issue,
  output logic           irqAck
);

  import isaPkg::*;
  import ctrlPkg::*;

  logic [OpW-1:0]   baseOp;
  logic             takeIrq;
  logic             useImm;
  logic             isBrl;
  logic             writes;
  aluOpT            aluOp;
  regIdxT           dstReg;
  logic [DataW-1:0] immVal;
  logic             fwdA;
  logic             fwdB;
  issueT            issueNext;

  // No second take while the ack is still in flight
  assign takeIrq = instrValid && irqReq && !irqAck;
  assign baseOp  = instrWord.opcode & ~immBit;

  assign rdAddrA = instrWord.ra;
  assign rdAddrB = instrWord.rb;

  always_comb begin
    aluOp  = aluPass;
    isBrl  = 1'b0;
    writes = 1'b1;
    useImm = instrWord.opcode[3];
    dstReg = instrWord.rd;
    immVal = {{(DataW-ImmW){instrWord[ImmW-1]}}, instrWord[ImmW-1:0]};
    case (baseOp)
      opAdd: aluOp = aluAdd;
      opSub: aluOp = aluSub;
      opAnd: aluOp = aluAnd;
      opOr:  aluOp = aluOr;
      opXor: aluOp = aluXor;
      opSrl: aluOp = aluSrl;
      opBrl: isBrl = 1'b1;   // Link value is the pc
      default: writes = 1'b0; // Unknown opcode does nothing
    endcase
    if (takeIrq) begin
      aluOp  = aluPass;
      isBrl  = 1'b1;
      writes = 1'b1;
      useImm = 1'b1;
      dstReg = linkReg;
      immVal = irqVector;
    end
  end

  // Hazard against the instruction one ahead
  assign fwdA = issue.valid && issue.we && (issue.rd == instrWord.ra);
  assign fwdB = issue.valid && issue.we && (issue.rd == instrWord.rb);

  always_comb begin
    issueNext.valid = instrValid;
    issueNext.srcA  = isBrl ? selPc : (fwdA ? selFwd : selReg);
    issueNext.srcB  = useImm ? selImm : (fwdB ? selFwd : selReg);
    issueNext.aluOp = aluOp;
    issueNext.rd    = dstReg;
    issueNext.we    = instrValid && writes && (dstReg != '0);  // r0 writes dropped
    issueNext.link  = instrValid && isBrl;
    issueNext.opA   = rdDataA;
    issueNext.opB   = rdDataB;
    issueNext.imm   = immVal;
    issueNext.pc    = instrPc;
  end

  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      issue  <= '0;
      irqAck <= 1'b0;
    end else begin
      issue  <= issueNext;
      irqAck <= takeIrq;
    end
  end

  noWriteR0: assert property (@(posedge gclk) disable iff (!arstN)
    issue.we |-> (issue.rd != '0));

  // Forwarding needs a writer ahead of it
  fwdNeedsWriter: assert property (@(posedge gclk) disable iff (!arstN)
    (issue.valid && issue.srcA == selFwd) |-> $past(issue.valid && issue.we));

endmodule

`default_nettype wire

// File: rtl/irqCtrl.sv
`default_nettype none

module irqCtrl #(
  parameter logic [31:0] IrqVectorReset = 32'h0000_0010
) (
  input  logic        gclk,
  input  logic        arstN,
  input  logic        cfgValid,
  input  logic [31:0] cfgData,
  input  logic        irq,
  input  logic        irqAck,
  output logic        irqReq,
  output logic [31:0] irqVector
);

  logic enable;
  logic pending;
  logic irqPrev;  // For rising edge detect

  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      enable    <= 1'b0;
      pending   <= 1'b0;
      irqPrev   <= 1'b0;
      irqVector <= IrqVectorReset;
    end else begin
      irqPrev <= irq;
      if (irqAck) begin
        enable  <= 1'b0;  // Taken interrupt disarms until rewritten
        pending <= 1'b0;
      end else if (irq && !irqPrev && enable) begin
        pending <= 1'b1;
      end
      // Config write wins over a same-cycle ack
      if (cfgValid) begin
        enable    <= cfgData[0];
        irqVector <= {cfgData[31:1], 1'b0};
        if (!cfgData[0]) pending <= 1'b0;
      end
    end
  end

  assign irqReq = pending && enable;

  // Decoder only acks a request it saw
  ackAfterReq: assert property (@(posedge gclk) disable iff (!arstN)
    irqAck |-> $past(irqReq));

endmodule

`default_nettype wire

// File: rtl/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

  // Operand source for the execute stage
  typedef enum logic [1:0] {
    selReg = 2'd0,
    selFwd = 2'd1,  // Result register of the previous instruction
    selPc  = 2'd2,
    selImm = 2'd3
  } srcSelT;

  typedef enum logic [2:0] {
    aluAdd  = 3'd0,
    aluSub  = 3'd1,
    aluAnd  = 3'd2,
    aluOr   = 3'd3,
    aluXor  = 3'd4,
    aluSrl  = 3'd5,
    aluPass = 3'd6   // Operand A straight through
  } aluOpT;

  // Issue stage payload
  typedef struct packed {
    logic                     valid;
    srcSelT                   srcA;
    srcSelT                   srcB;
    aluOpT                    aluOp;
    isaPkg::regIdxT           rd;
    logic                     we;
    logic                     link;
    logic [isaPkg::DataW-1:0] opA;
    logic [isaPkg::DataW-1:0] opB;
    logic [isaPkg::DataW-1:0] imm;
    logic [isaPkg::DataW-1:0] pc;
  } issueT;

  // Writeback payload with valid set only for register writes
  typedef struct packed {
    logic                     valid;
    isaPkg::regIdxT           rd;
    logic [isaPkg::DataW-1:0] data;
    logic                     link;
  } wbT;

endpackage

`default_nettype wire

// File: rtl/isaPkg.sv
`default_nettype none

package isaPkg;

  // Field widths of the instruction word
  localparam int OpW   = 6;
  localparam int RegW  = 5;
  localparam int AltW  = 11;
  localparam int ImmW  = 16;  // Low bits of the word double as immediate
  localparam int DataW = 32;

  typedef logic [RegW-1:0] regIdxT;

  typedef struct packed {
    logic [OpW-1:0]  opcode;
    regIdxT          rd;
    regIdxT          ra;
    regIdxT          rb;
    logic [AltW-1:0] alt;
  } instrT;

  // Immediate forms set bit 3 of these register opcodes
  localparam logic [OpW-1:0] opAdd  = 6'o00;
  localparam logic [OpW-1:0] opSub  = 6'o01;
  localparam logic [OpW-1:0] opOr   = 6'o40;
  localparam logic [OpW-1:0] opAnd  = 6'o41;
  localparam logic [OpW-1:0] opXor  = 6'o42;
  localparam logic [OpW-1:0] opSrl  = 6'o44;
  localparam logic [OpW-1:0] opBrl  = 6'o46;
  localparam logic [OpW-1:0] immBit = 6'o10;

  localparam regIdxT linkReg = 5'd14;  // Interrupt return address

endpackage

`default_nettype wire
